//--- hw/addr_calc.sv
`timescale 1ns/1ps

module addr_calc (
    input  logic                         SYS_CLK,
    input  logic                         SYS_NRST,
    input  raddr_pkg::walk_ctrl_t        walk_i,
    input  raddr_pkg::rd_step_t          step_i,
    input  logic                         padding_i,
    input  logic [raddr_pkg::PIC_W-1:0]  pic_size_i,
    input  logic [raddr_pkg::ADDR_W-1:0] wr_base_i,
    input  logic [1:0]                   bank_status_i,
    output raddr_pkg::sram_rd_cmd_t      rd_cmd_o
);

    logic [1:0]                    dx_c;
    logic [1:0]                    dy_c;
    logic [1:0]                    dx_q;
    logic [1:0]                    dy_q;
    logic [3:0]                    idx_q;
    logic [3:0]                    idx_q2;
    logic                          full_q;
    logic                          vld_d1;
    logic                          vld_d2;
    logic [raddr_pkg::PIC_W-1:0]   px;
    logic [raddr_pkg::PIC_W-1:0]   py;
    logic [raddr_pkg::PIC_W-1:0]   px_abs;
    logic                          out_c;
    logic [raddr_pkg::ADDR_W-1:0]  col_base;
    logic [raddr_pkg::ADDR_W-1:0]  word_c;
    logic [raddr_pkg::BANK_W-1:0]  bank_c;
    logic [raddr_pkg::ADDR_W-1:0]  word_q;
    logic [raddr_pkg::BANK_W-1:0]  bank_q;
    logic                          pad_q;
    logic [3:0]                    size_q;

    // ==================================================
    // stage 1: offset inside the window
    // ==================================================
    always_comb begin
        dx_c = '0;
        dy_c = '0;
        case (walk_i.state)
            raddr_pkg::W_FULL: begin
                dx_c = step_i.col;
                dy_c = step_i.row;
            end
            raddr_pkg::W_DOWN1, raddr_pkg::W_DOWN2: begin
                dx_c = step_i.col;
                dy_c = 2'd2;  // bottom row
            end
            raddr_pkg::W_RIGHT: begin
                dx_c = 2'd2;
                dy_c = step_i.col;
            end
            raddr_pkg::W_LEFT: dy_c = step_i.col;
            default: ;
        endcase
    end

    always_ff @(posedge SYS_CLK) begin
        dx_q   <= dx_c;
        dy_q   <= dy_c;
        idx_q  <= 4'(dy_c) * 4'd3 + 4'(dx_c);  // row-major register slot
        full_q <= (walk_i.state == raddr_pkg::W_FULL);
    end

    // ==================================================
    // stage 2: address, bank, padding
    // ==================================================
    assign px = raddr_pkg::PIC_W'(walk_i.ox) + raddr_pkg::PIC_W'(dx_q);
    assign py = walk_i.oy + raddr_pkg::PIC_W'(dy_q);

    // odd columns sit one picture height further in the bank
    assign col_base = px[0] ? raddr_pkg::ADDR_W'(pic_size_i) << 3 : '0;
    assign word_c   = (raddr_pkg::ADDR_W'(py) << 3) + raddr_pkg::ADDR_W'(walk_i.bit_idx)
                    + wr_base_i + col_base;
    assign bank_c   = raddr_pkg::BANK_W'(px[1]) + bank_status_i
                    + raddr_pkg::BANK_W'(px[1] & bank_status_i[1]);

    // column in picture terms where line n starts 2*(n-1) columns in
    assign px_abs = px + ((walk_i.line_cnt - 1'b1) << 1) - raddr_pkg::PIC_W'(padding_i);
    assign out_c  = (px_abs >= pic_size_i) || (py >= pic_size_i);  // negative wraps high

    always_ff @(posedge SYS_CLK) begin
        word_q <= word_c;
        bank_q <= bank_c;
        idx_q2 <= idx_q;
        size_q <= full_q ? 4'(raddr_pkg::FULL_READS) : 4'(raddr_pkg::EDGE_READS);
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            vld_d1 <= 1'b0;
            vld_d2 <= 1'b0;
            pad_q  <= 1'b0;
        end else begin
            vld_d1 <= step_i.active;
            vld_d2 <= vld_d1;
            pad_q  <= vld_d1 && out_c;
        end
    end

    assign rd_cmd_o.addr    = {bank_q, word_q};
    assign rd_cmd_o.valid   = vld_d2;
    assign rd_cmd_o.pad_rst = pad_q;
    assign rd_cmd_o.size    = size_q;
    assign rd_cmd_o.bit_idx = walk_i.bit_idx;  // only moves on a response
    assign rd_cmd_o.reg_idx = idx_q2;

    // one size for the whole burst
    a_size_stable: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        vld_d2 && $past(vld_d2) |-> size_q == $past(size_q));

endmodule

//--- hw/raddr_gen_top.sv
`timescale 1ns/1ps

module raddr_gen_top (
    input  logic                         SYS_CLK,
    input  logic                         SYS_NRST,
    input  logic                         line_start_i,   // one output line
    input  logic                         frame_sop_i,
    input  raddr_pkg::conv_mode_e        mode_i,
    input  logic                         padding_i,
    input  logic [raddr_pkg::PIC_W-1:0]  pic_size_i,
    input  logic [raddr_pkg::ADDR_W-1:0] wr_base_i,
    input  logic [1:0]                   bank_status_i,
    input  logic                         rsp_i,          // register array took a burst
    input  logic                         array_full_i,
    output raddr_pkg::sram_rd_cmd_t      rd_cmd_o,
    output logic                         line_end_o
);

    raddr_pkg::walk_ctrl_t walk;
    raddr_pkg::rd_step_t   step;

    // ==================================================
    // window walk, burst stepping, address forming
    // ==================================================
    window_walker u_walker (
        .SYS_CLK      (SYS_CLK),
        .SYS_NRST     (SYS_NRST),
        .line_start_i (line_start_i),
        .frame_sop_i  (frame_sop_i),
        .mode_i       (mode_i),
        .padding_i    (padding_i),
        .pic_size_i   (pic_size_i),
        .rsp_i        (rsp_i),
        .walk_o       (walk),
        .line_end_o   (line_end_o)
    );

    read_sequencer u_seq (
        .SYS_CLK      (SYS_CLK),
        .SYS_NRST     (SYS_NRST),
        .walk_i       (walk),
        .rsp_i        (rsp_i),
        .array_full_i (array_full_i),
        .step_o       (step)
    );

    addr_calc u_addr (
        .SYS_CLK       (SYS_CLK),
        .SYS_NRST      (SYS_NRST),
        .walk_i        (walk),
        .step_i        (step),
        .padding_i     (padding_i),
        .pic_size_i    (pic_size_i),
        .wr_base_i     (wr_base_i),
        .bank_status_i (bank_status_i),
        .rd_cmd_o      (rd_cmd_o)
    );

endmodule

//--- hw/raddr_pkg.sv
package raddr_pkg;

    // ==================================================
    // widths and counts
    // ==================================================
    localparam int ADDR_W     = 10;  // word address inside one bank
    localparam int BANK_W     = 2;
    localparam int PIC_W      = 6;   // picture size, coordinates, line count
    localparam int BIT_W      = 3;
    localparam int PLANES     = 8;   // bursts per window
    localparam int FULL_READS = 9;
    localparam int EDGE_READS = 3;

    // ==================================================
    // opcodes and states
    // ==================================================
    typedef enum logic [1:0] {
        SNAKE   = 2'd0,  // right, down, left, down
        LINE_S1 = 2'd1,
        LINE_S2 = 2'd2
    } conv_mode_e;

    // window walker states
    typedef enum logic [2:0] {
        W_IDLE, W_FULL, W_RIGHT, W_DOWN1, W_LEFT, W_DOWN2, W_DONE
    } walk_state_e;

    // burst request states
    typedef enum logic [2:0] {
        R_IDLE, R_REQ, R_GEN, R_CHK, R_WAIT
    } req_state_e;

    // ==================================================
    // shared bundles
    // ==================================================
    typedef struct packed {
        walk_state_e              state;
        logic                     ox;         // origin column
        logic [PIC_W-1:0]         oy;         // origin row that may go negative
        logic [PIC_W-1:0]         line_cnt;   // starts since frame sop
        logic [BIT_W-1:0]         bit_idx;
        logic                     mat_rcv;    // eighth response of a window
        logic                     line_done;  // last window of the line
    } walk_ctrl_t;

    typedef struct packed {
        logic                     active;
        logic [1:0]               col;
        logic [1:0]               row;
    } rd_step_t;

    typedef struct packed {
        logic [BANK_W+ADDR_W-1:0] addr;       // bank on top
        logic                     valid;
        logic                     pad_rst;
        logic [3:0]               size;
        logic [BIT_W-1:0]         bit_idx;
        logic [3:0]               reg_idx;
    } sram_rd_cmd_t;

endpackage

//--- hw/read_sequencer.sv
`timescale 1ns/1ps

module read_sequencer (
    input  logic                  SYS_CLK,
    input  logic                  SYS_NRST,
    input  raddr_pkg::walk_ctrl_t walk_i,
    input  logic                  rsp_i,
    input  logic                  array_full_i,
    output raddr_pkg::rd_step_t   step_o
);

    raddr_pkg::req_state_e state_q;
    raddr_pkg::req_state_e state_d;
    logic                  active_q;
    logic [1:0]            col_q;
    logic [1:0]            row_q;
    logic                  issue;
    logic                  last;

    // the first burst of a line issues straight from idle
    assign issue = (state_q == raddr_pkg::R_REQ)
                || (state_q == raddr_pkg::R_IDLE && walk_i.state == raddr_pkg::W_FULL);

    // 3x3 in full, one column or row otherwise
    assign last = active_q && (col_q == 2'd2)
               && (walk_i.state != raddr_pkg::W_FULL || row_q == 2'd2);

    // ==================================================
    // request state machine
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            raddr_pkg::R_IDLE: begin
                if (issue) begin
                    state_d = raddr_pkg::R_GEN;
                end
            end
            raddr_pkg::R_REQ: state_d = raddr_pkg::R_GEN;
            raddr_pkg::R_GEN: begin
                if (last) begin
                    state_d = raddr_pkg::R_CHK;
                end
            end
            raddr_pkg::R_CHK: begin
                if (walk_i.line_done) begin
                    state_d = raddr_pkg::R_IDLE;
                end else if (rsp_i) begin
                    state_d = raddr_pkg::R_WAIT;
                end
            end
            raddr_pkg::R_WAIT: begin
                if (!array_full_i) begin  // register array has room
                    state_d = raddr_pkg::R_REQ;
                end
            end
            default: state_d = raddr_pkg::R_IDLE;
        endcase
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            state_q <= raddr_pkg::R_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================================================
    // burst step counters
    // ==================================================
    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            active_q <= 1'b0;
            col_q    <= '0;
            row_q    <= '0;
        end else if (active_q) begin
            if (last) begin
                active_q <= 1'b0;
                col_q    <= '0;
                row_q    <= '0;
            end else if (col_q == 2'd2) begin
                col_q <= '0;
                row_q <= row_q + 1'b1;
            end else begin
                col_q <= col_q + 1'b1;
            end
        end else if (issue) begin
            active_q <= 1'b1;
        end
    end

    assign step_o.active = active_q;
    assign step_o.col    = col_q;
    assign step_o.row    = row_q;

    a_burst_len: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        $rose(active_q) |-> ##[1:raddr_pkg::FULL_READS] !active_q);

endmodule

//--- hw/window_walker.sv
`timescale 1ns/1ps

module window_walker (
    input  logic                        SYS_CLK,
    input  logic                        SYS_NRST,
    input  logic                        line_start_i,
    input  logic                        frame_sop_i,
    input  raddr_pkg::conv_mode_e       mode_i,
    input  logic                        padding_i,
    input  logic [raddr_pkg::PIC_W-1:0] pic_size_i,
    input  logic                        rsp_i,
    output raddr_pkg::walk_ctrl_t       walk_o,
    output logic                        line_end_o
);

    raddr_pkg::walk_state_e        state_q;
    raddr_pkg::walk_state_e        state_d;
    logic [raddr_pkg::BIT_W-1:0]   bit_q;
    logic [raddr_pkg::PIC_W:0]     mat_cnt_q;
    logic [raddr_pkg::PIC_W:0]     half_win;   // windows per column pass
    logic [raddr_pkg::PIC_W:0]     line_win;   // windows per line
    logic                          ox_q;
    logic [raddr_pkg::PIC_W-1:0]   oy_q;
    logic [raddr_pkg::PIC_W-1:0]   oy_init;
    logic [raddr_pkg::PIC_W-1:0]   line_q;
    logic                          mat_rcv;
    logic                          half_done;
    logic                          line_done;

    // ==================================================
    // response counting
    // ==================================================
    assign mat_rcv = rsp_i && (bit_q == raddr_pkg::BIT_W'(raddr_pkg::PLANES - 1));

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            bit_q     <= '0;
            mat_cnt_q <= '0;
        end else if (line_start_i) begin
            bit_q     <= '0;
            mat_cnt_q <= '0;
        end else if (rsp_i) begin
            bit_q <= mat_rcv ? '0 : bit_q + 1'b1;
            if (mat_rcv) begin
                mat_cnt_q <= mat_cnt_q + 1'b1;
            end
        end
    end

    // pic_size - 2 + 2*padding
    assign half_win = (raddr_pkg::PIC_W+1)'(pic_size_i)
                    + (raddr_pkg::PIC_W+1)'({padding_i, 1'b0})
                    - (raddr_pkg::PIC_W+1)'(2);
    assign line_win = (mode_i == raddr_pkg::LINE_S2) ? half_win - 1'b1 : half_win << 1;

    assign half_done = mat_rcv && (mode_i == raddr_pkg::LINE_S1)
                    && (mat_cnt_q == half_win - 1'b1);
    assign line_done = mat_rcv && (mat_cnt_q == line_win - 1'b1);

    // ==================================================
    // window state machine
    // ==================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            raddr_pkg::W_IDLE: begin
                if (line_start_i) begin
                    state_d = raddr_pkg::W_FULL;
                end
            end
            raddr_pkg::W_DONE: state_d = raddr_pkg::W_IDLE;
            default: begin
                if (line_done) begin
                    state_d = raddr_pkg::W_DONE;
                end else if (half_done) begin
                    state_d = raddr_pkg::W_FULL;  // second column pass
                end else if (mat_rcv) begin
                    case (state_q)
                        raddr_pkg::W_FULL:  state_d = (mode_i == raddr_pkg::SNAKE) ?
                                                      raddr_pkg::W_RIGHT : raddr_pkg::W_DOWN1;
                        raddr_pkg::W_RIGHT: state_d = raddr_pkg::W_DOWN1;
                        raddr_pkg::W_DOWN1: state_d = (mode_i == raddr_pkg::SNAKE) ?
                                                      raddr_pkg::W_LEFT : raddr_pkg::W_DOWN1;
                        raddr_pkg::W_LEFT:  state_d = raddr_pkg::W_DOWN2;
                        default:            state_d = raddr_pkg::W_RIGHT;
                    endcase
                end
            end
        endcase
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            state_q <= raddr_pkg::W_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // ==================================================
    // origin and line count
    // ==================================================
    assign oy_init = raddr_pkg::PIC_W'(0) - raddr_pkg::PIC_W'(padding_i);  // top padding row

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            ox_q <= 1'b0;
            oy_q <= '0;
        end else if (line_start_i) begin
            ox_q <= 1'b0;
            oy_q <= oy_init;
        end else if (half_done) begin
            ox_q <= 1'b1;
            oy_q <= oy_init;
        end else if (mat_rcv) begin
            // column flips on a sideways move, row steps on a downward one
            if (state_d == raddr_pkg::W_RIGHT || state_d == raddr_pkg::W_LEFT) begin
                ox_q <= ~ox_q;
            end
            if (state_d == raddr_pkg::W_DOWN1 || state_d == raddr_pkg::W_DOWN2) begin
                oy_q <= oy_q + 1'b1;
            end
        end
    end

    always_ff @(posedge SYS_CLK or negedge SYS_NRST) begin
        if (!SYS_NRST) begin
            line_q <= '0;
        end else if (frame_sop_i) begin
            line_q <= '0;
        end else if (line_start_i) begin
            line_q <= line_q + 1'b1;
        end
    end

    assign walk_o.state     = state_q;
    assign walk_o.ox        = ox_q;
    assign walk_o.oy        = oy_q;
    assign walk_o.line_cnt  = line_q;
    assign walk_o.bit_idx   = bit_q;
    assign walk_o.mat_rcv   = mat_rcv;
    assign walk_o.line_done = line_done;
    assign line_end_o       = (state_q == raddr_pkg::W_DONE);

    // a new line is only requested once the previous one has drained
    a_start_in_idle: assert property (@(posedge SYS_CLK) disable iff (!SYS_NRST)
        line_start_i |-> state_q == raddr_pkg::W_IDLE);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f src.f \
    && ./obj_dir/Vtb_top | tee /dev/stderr | grep -qx "ALL CHECKS PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- src.f
hw/raddr_pkg.sv
hw/window_walker.sv
hw/read_sequencer.sv
hw/addr_calc.sv
hw/raddr_gen_top.sv
testbench/tb_checker.sv
testbench/tb_top.sv

//--- testbench/tb_checker.sv
`timescale 1ns/1ps

module tb_checker (
    input  logic                         SYS_CLK,
    input  logic                         SYS_NRST,
    input  logic                         line_start_i,
    input  logic                         frame_sop_i,
    input  raddr_pkg::conv_mode_e        mode_i,
    input  logic                         padding_i,
    input  logic [raddr_pkg::PIC_W-1:0]  pic_size_i,
    input  logic [raddr_pkg::ADDR_W-1:0] wr_base_i,
    input  logic [1:0]                   bank_status_i,
    input  logic                         rsp_i,
    input  logic                         array_full_i,
    input  raddr_pkg::sram_rd_cmd_t      rd_cmd_i,
    input  logic                         line_end_i,
    output int                           reads_o,
    output int                           mism_o,
    output int                           proto_o,
    output int                           lines_o
);

    raddr_pkg::conv_mode_e        cfg_mode;
    logic                         cfg_pad;
    logic [raddr_pkg::PIC_W-1:0]  cfg_pic;
    logic [raddr_pkg::ADDR_W-1:0] cfg_base;
    logic [1:0]                   cfg_bs;
    int                           cfg_line;
    int                           line_num;
    int                           wins;
    int                           win_n;
    int                           plane_n;
    int                           read_n;
    logic                         busy;
    logic                         hold_rsp;  // burst done and its response pending
    logic                         waiting;   // response seen and the array may be full

    // expected read k of plane b in window w of the current line
    function automatic raddr_pkg::sram_rd_cmd_t expected_read(input int w, input int b,
                                                              input int k);
        raddr_pkg::sram_rd_cmd_t      cmd;
        int                           h;
        int                           ox;
        int                           oy;
        int                           dx;
        int                           dy;
        logic                         full;
        logic [raddr_pkg::PIC_W-1:0]  px;
        logic [raddr_pkg::PIC_W-1:0]  py;
        logic [raddr_pkg::PIC_W-1:0]  pxa;
        logic [raddr_pkg::ADDR_W-1:0] word;
        logic [1:0]                   bank;
        h  = int'(cfg_pic) - 2 + 2 * int'(cfg_pad);
        ox = 0;
        if (cfg_mode == raddr_pkg::SNAKE) begin
            ox   = ((w + 1) / 2) % 2;  // flips on the right and left moves
            oy   = w / 2;
            full = (w == 0);
        end else if (cfg_mode == raddr_pkg::LINE_S1 && w >= h) begin
            ox   = 1;  // second column pass
            oy   = w - h;
            full = (w == h);
        end else begin
            oy   = w;
            full = (w == 0);
        end
        if (full) begin
            dx = k % 3;
            dy = k / 3;
        end else if (cfg_mode != raddr_pkg::SNAKE || w % 2 == 0) begin
            dx = k;  // new bottom row
            dy = 2;
        end else if (w % 4 == 1) begin
            dx = 2;
            dy = k;
        end else begin
            dx = 0;
            dy = k;
        end
        px   = raddr_pkg::PIC_W'(ox + dx);
        py   = raddr_pkg::PIC_W'(oy - int'(cfg_pad) + dy);
        word = raddr_pkg::ADDR_W'(int'(py) * 8 + b + int'(cfg_base)
                                  + (px[0] ? int'(cfg_pic) * 8 : 0));
        bank = 2'(int'(px[1]) + int'(cfg_bs) + int'(px[1] & cfg_bs[1]));
        pxa  = raddr_pkg::PIC_W'(int'(px) + 2 * (cfg_line - 1) - int'(cfg_pad));
        cmd.addr    = {bank, word};
        cmd.valid   = 1'b1;
        cmd.pad_rst = (pxa >= cfg_pic) || (py >= cfg_pic);
        cmd.size    = full ? 4'd9 : 4'd3;
        cmd.bit_idx = raddr_pkg::BIT_W'(b);
        cmd.reg_idx = 4'(3 * dy + dx);
        return cmd;
    endfunction

    // ==================================================
    // comparison
    // ==================================================
    always @(posedge SYS_CLK) begin
        raddr_pkg::sram_rd_cmd_t exp_cmd;
        if (!SYS_NRST) begin
            line_num = 0;
            busy     = 1'b0;
            hold_rsp = 1'b0;
            waiting  = 1'b0;
            read_n   = 0;
            reads_o  = 0;
            mism_o   = 0;
            proto_o  = 0;
            lines_o  = 0;
        end else begin
            if (frame_sop_i) begin
                line_num = 0;
            end
            if (line_start_i) begin
                line_num++;
                cfg_mode = mode_i;
                cfg_pad  = padding_i;
                cfg_pic  = pic_size_i;
                cfg_base = wr_base_i;
                cfg_bs   = bank_status_i;
                cfg_line = line_num;
                wins     = int'(pic_size_i) - 2 + 2 * int'(padding_i);
                wins     = (mode_i == raddr_pkg::LINE_S2) ? wins - 1 : 2 * wins;
                win_n    = 0;
                plane_n  = 0;
                read_n   = 0;
                busy     = 1'b1;
                hold_rsp = 1'b0;
                waiting  = 1'b0;
            end
            if (rsp_i) begin
                hold_rsp = 1'b0;
                waiting  = 1'b1;
            end else if (waiting && !array_full_i) begin
                waiting = 1'b0;  // sequencer leaves its wait here
            end
            if (rd_cmd_i.valid) begin
                if (!busy || win_n >= wins) begin
                    proto_o++;
                    $display("at %0t: a read was issued with no window left in the line", $time);
                end else if (hold_rsp || waiting) begin
                    proto_o++;
                    $display("at %0t: a read was issued before the array released the burst",
                             $time);
                end else begin
                    exp_cmd = expected_read(win_n, plane_n, read_n);
                    reads_o++;
                    if (rd_cmd_i !== exp_cmd) begin
                        mism_o++;
                        $write("[FAIL] %0t: line %0d win %0d plane %0d read %0d got ",
                               $time, cfg_line, win_n, plane_n, read_n);
                        $write("addr %h pad %b size %0d bit %0d reg %0d, ",
                               rd_cmd_i.addr, rd_cmd_i.pad_rst, rd_cmd_i.size,
                               rd_cmd_i.bit_idx, rd_cmd_i.reg_idx);
                        $display("expected addr %h pad %b size %0d bit %0d reg %0d",
                                 exp_cmd.addr, exp_cmd.pad_rst, exp_cmd.size,
                                 exp_cmd.bit_idx, exp_cmd.reg_idx);
                    end
                    read_n++;
                    if (read_n == int'(exp_cmd.size)) begin
                        read_n   = 0;
                        hold_rsp = 1'b1;
                        plane_n++;
                        if (plane_n == raddr_pkg::PLANES) begin
                            plane_n = 0;
                            win_n++;
                        end
                    end
                end
            end else if (read_n != 0) begin
                proto_o++;
                $display("at %0t: a burst broke off after %0d reads", $time, read_n);
                read_n = 0;
            end
            if (line_end_i) begin
                if (!busy || win_n != wins || read_n != 0 || hold_rsp) begin
                    proto_o++;
                    $display("at %0t: line end came after %0d of %0d windows", $time,
                             win_n, wins);
                end
                busy = 1'b0;
                lines_o++;
            end
        end
    end

endmodule

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top;

    localparam int LINES       = 12;
    localparam int FRAME_LINES = 4;  // frame sop ahead of every fourth line

    logic                         SYS_CLK;
    logic                         SYS_NRST;
    logic                         line_start;
    logic                         frame_sop;
    raddr_pkg::conv_mode_e        mode;
    logic                         padding;
    logic [raddr_pkg::PIC_W-1:0]  pic_size;
    logic [raddr_pkg::ADDR_W-1:0] wr_base;
    logic [1:0]                   bank_status;
    logic                         rsp;
    logic                         array_full;
    raddr_pkg::sram_rd_cmd_t      rd_cmd;
    logic                         line_end;

    logic [31:0]                  lfsr_q = 32'h26a4877b;
    int                           budget = 0;  // watchdog cycles
    int                           reads;
    int                           mism;
    int                           proto;
    int                           lines_done;

    raddr_pkg::conv_mode_e        line_mode [LINES];
    logic                         line_pad  [LINES];
    logic [raddr_pkg::PIC_W-1:0]  line_pic  [LINES];
    logic [raddr_pkg::ADDR_W-1:0] line_base [LINES];
    logic [1:0]                   line_bs   [LINES];

    // fibonacci lfsr with taps 32 22 2 1 and one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
            lfsr_q = {lfsr_q[30:0], fb};
            val    = {val[30:0], fb};
        end
        return val;
    endfunction

    // per plane 9 reads for a full window and 3 for a sliding one
    function automatic int line_reads(input int m, input int pic, input int pad);
        int h;
        int wins;
        h    = pic - 2 + 2 * pad;
        wins = (m == int'(raddr_pkg::LINE_S2)) ? h - 1 : 2 * h;
        return raddr_pkg::PLANES * (3 * wins + 6 * ((m == int'(raddr_pkg::LINE_S1)) ? 2 : 1));
    endfunction

    initial begin
        SYS_CLK = 1'b0;
        forever #20 SYS_CLK = ~SYS_CLK;
    end

    raddr_gen_top DUT (
        .SYS_CLK       (SYS_CLK),
        .SYS_NRST      (SYS_NRST),
        .line_start_i  (line_start),
        .frame_sop_i   (frame_sop),
        .mode_i        (mode),
        .padding_i     (padding),
        .pic_size_i    (pic_size),
        .wr_base_i     (wr_base),
        .bank_status_i (bank_status),
        .rsp_i         (rsp),
        .array_full_i  (array_full),
        .rd_cmd_o      (rd_cmd),
        .line_end_o    (line_end)
    );

    tb_checker u_check (
        .SYS_CLK       (SYS_CLK),
        .SYS_NRST      (SYS_NRST),
        .line_start_i  (line_start),
        .frame_sop_i   (frame_sop),
        .mode_i        (mode),
        .padding_i     (padding),
        .pic_size_i    (pic_size),
        .wr_base_i     (wr_base),
        .bank_status_i (bank_status),
        .rsp_i         (rsp),
        .array_full_i  (array_full),
        .rd_cmd_i      (rd_cmd),
        .line_end_i    (line_end),
        .reads_o       (reads),
        .mism_o        (mism),
        .proto_o       (proto),
        .lines_o       (lines_done)
    );

    // ==================================================
    // line stimulus
    // ==================================================
    initial begin
        int mode_off;
        int pad_off;
        SYS_NRST    = 1'b0;
        line_start  = 1'b0;
        frame_sop   = 1'b0;
        mode        = raddr_pkg::SNAKE;
        padding     = 1'b0;
        pic_size    = raddr_pkg::PIC_W'(5);
        wr_base     = '0;
        bank_status = '0;
        mode_off    = int'(lfsr_bits(2) % 3);
        pad_off     = int'(lfsr_bits(1));
        for (int i = 0; i < LINES; i++) begin
            // modes rotate every line and padding flips every three
            line_mode[i] = raddr_pkg::conv_mode_e'((i + mode_off) % 3);
            line_pad[i]  = 1'((i / 3 + pad_off) % 2);
            line_pic[i]  = raddr_pkg::PIC_W'(5 + lfsr_bits(3) % 6);
            line_base[i] = raddr_pkg::ADDR_W'(lfsr_bits(10));
            line_bs[i]   = 2'(lfsr_bits(2));
            budget += 40 * line_reads(int'(line_mode[i]), int'(line_pic[i]), int'(line_pad[i]));
        end
        repeat (3) @(posedge SYS_CLK);
        SYS_NRST <= 1'b1;
        repeat (2) @(posedge SYS_CLK);
        for (int i = 0; i < LINES; i++) begin
            if (i % FRAME_LINES == 0) begin
                frame_sop <= 1'b1;
                @(posedge SYS_CLK);
                frame_sop <= 1'b0;
            end
            mode        <= line_mode[i];
            padding     <= line_pad[i];
            pic_size    <= line_pic[i];
            wr_base     <= line_base[i];
            bank_status <= line_bs[i];
            @(posedge SYS_CLK);
            line_start <= 1'b1;
            @(posedge SYS_CLK);
            line_start <= 1'b0;
            do @(posedge SYS_CLK); while (!line_end);
            do @(posedge SYS_CLK); while (array_full);  // last stall has to clear
        end
        repeat (8) @(posedge SYS_CLK);  // stray reads after the last line
        $display("reads %0d, mismatches %0d, protocol errors %0d, lines %0d of %0d",
                 reads, mism, proto, lines_done, LINES);
        if (mism == 0 && proto == 0 && lines_done == LINES) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // register array model answers each burst and sometimes runs full
    initial begin
        int   delay;
        int   stall;
        logic seen;
        rsp        = 1'b0;
        array_full = 1'b0;
        seen       = 1'b0;
        forever begin
            @(posedge SYS_CLK);
            if (rd_cmd.valid) begin
                seen = 1'b1;
            end else if (seen) begin
                seen  = 1'b0;
                delay = 1 + int'(lfsr_bits(3) % 6);
                stall = (lfsr_bits(2) == 0) ? 1 + int'(lfsr_bits(3)) : 0;
                repeat (delay - 1) @(posedge SYS_CLK);
                rsp        <= 1'b1;
                array_full <= (stall != 0);
                @(posedge SYS_CLK);
                rsp <= 1'b0;
                repeat (stall) @(posedge SYS_CLK);
                array_full <= 1'b0;
            end
        end
    end

    initial begin
        wait (budget != 0);
        repeat (budget) @(posedge SYS_CLK);
        $display("timeout: the lines did not finish within %0d cycles", budget);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule
